// ==== rtl/periph_pkg.sv ====
// ==========================================================
// Peripheral package: memory map, register indices and the
// timer mode and interrupt source encodings
// ==========================================================
`default_nettype none

package periph_pkg;

    localparam int addr_width   = 16;
    localparam int data_width   = 8;
    localparam int offset_width = 4;
    localparam int irq_lines    = 4;

    localparam logic [addr_width-1:0] base_addr = 16'hFF00;

    // block windows inside the local offset space
    localparam logic [offset_width-1:0] intmux_off    = 4'd0;
    localparam logic [offset_width-1:0] intmux_size   = 4'd5;
    localparam logic [offset_width-1:0] gpio_off      = 4'd5;
    localparam logic [offset_width-1:0] gpio_size     = 4'd4;
    // timer_off is taken by the mode encoding below
    localparam logic [offset_width-1:0] timer_blk_off = 4'd9;
    localparam logic [offset_width-1:0] timer_size    = 4'd4;
    localparam logic [offset_width-1:0] total_size    = intmux_size + gpio_size + timer_size;

    // interrupt mux registers
    localparam logic [offset_width-1:0] intmux_route0  = 4'd0;
    localparam logic [offset_width-1:0] intmux_route1  = 4'd1;
    localparam logic [offset_width-1:0] intmux_route2  = 4'd2;
    localparam logic [offset_width-1:0] intmux_route3  = 4'd3;
    localparam logic [offset_width-1:0] intmux_pending = 4'd4;

    // gpio registers
    localparam logic [offset_width-1:0] gpio_gpo_lo = 4'd0;
    localparam logic [offset_width-1:0] gpio_gpo_hi = 4'd1;
    localparam logic [offset_width-1:0] gpio_gpi_lo = 4'd2;
    localparam logic [offset_width-1:0] gpio_gpi_hi = 4'd3;

    // timer registers
    localparam logic [offset_width-1:0] timer_ctrl     = 4'd0;
    localparam logic [offset_width-1:0] timer_prescale = 4'd1;
    localparam logic [offset_width-1:0] timer_compare  = 4'd2;
    localparam logic [offset_width-1:0] timer_count    = 4'd3;

    typedef enum logic [1:0] {timer_off, timer_one_shot, timer_periodic} timer_mode_e;
    typedef enum logic [1:0] {src_none, src_gpio, src_timer} irq_source_e;

endpackage

`default_nettype wire

// ==== rtl/periph_gpio.sv ====
// ==========================================================
// GPIO block: 16-bit output register, synchronised input and
// rising-edge interrupt on input bit 0
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module periph_gpio import periph_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     sel,
    input  wire  [offset_width-1:0] offset,
    input  wire  [data_width-1:0]   data_in,
    input  wire                     write_en,
    output logic [data_width-1:0]   rdata,
    input  wire  [15:0]             gpi,
    output logic [15:0]             gpo,
    output logic                    gpio_irq
);

    logic                    hit;
    logic                    wr;
    logic [offset_width-1:0] idx;
    logic [15:0]             gpi_meta;
    logic [15:0]             gpi_sync;
    logic                    gpi0_prev;

    assign hit = sel && (offset >= gpio_off) && (offset < gpio_off + gpio_size);
    assign idx = offset - gpio_off;
    assign wr  = hit && write_en;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            gpo       <= '0;
            gpi_meta  <= '0;
            gpi_sync  <= '0;
            gpi0_prev <= 1'b0;
            gpio_irq  <= 1'b0;
        end
        else
        begin
            if (wr && idx == gpio_gpo_lo)
                gpo[7:0] <= data_in;
            if (wr && idx == gpio_gpo_hi)
                gpo[15:8] <= data_in;
            // two-flop synchroniser
            gpi_meta  <= gpi;
            gpi_sync  <= gpi_meta;
            gpi0_prev <= gpi_sync[0];
            gpio_irq  <= gpi_sync[0] && !gpi0_prev;
        end
    end

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                gpio_gpo_lo: rdata = gpo[7:0];
                gpio_gpo_hi: rdata = gpo[15:8];
                gpio_gpi_lo: rdata = gpi_sync[7:0];
                gpio_gpi_hi: rdata = gpi_sync[15:8];
                default:     rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/periph_timer.sv ====
// ==========================================================
// Timer block: prescaled up-counter with compare match,
// one-shot and periodic modes, and an interrupt pulse
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module periph_timer import periph_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     sel,
    input  wire  [offset_width-1:0] offset,
    input  wire  [data_width-1:0]   data_in,
    input  wire                     write_en,
    output logic [data_width-1:0]   rdata,
    output logic                    timer_irq
);

    logic                    hit;
    logic                    wr;
    logic [offset_width-1:0] idx;
    logic                    ctrl_wr;
    logic                    tick;
    logic                    match;
    timer_mode_e             mode_q;
    logic [data_width-1:0]   prescale_q;
    logic [data_width-1:0]   compare_q;
    logic [data_width-1:0]   presc_cnt;
    logic [data_width-1:0]   count_q;

    assign hit     = sel && (offset >= timer_blk_off) && (offset < timer_blk_off + timer_size);
    assign idx     = offset - timer_blk_off;
    assign wr      = hit && write_en;
    assign ctrl_wr = wr && idx == timer_ctrl;

    // one tick every prescale + 1 cycles while running
    assign tick  = (mode_q != timer_off) && (presc_cnt == prescale_q);
    assign match = tick && (count_q == compare_q);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mode_q     <= timer_off;
            prescale_q <= '0;
            compare_q  <= '0;
            presc_cnt  <= '0;
            count_q    <= '0;
            timer_irq  <= 1'b0;
        end
        else
        begin
            if (wr && idx == timer_prescale)
                prescale_q <= data_in;
            if (wr && idx == timer_compare)
                compare_q <= data_in;

            if (ctrl_wr)
            begin
                // unused encoding 3 stops the timer
                mode_q    <= (data_in[1:0] == 2'd3) ? timer_off : timer_mode_e'(data_in[1:0]);
                presc_cnt <= '0;
                count_q   <= '0;
                timer_irq <= 1'b0;
            end
            else
            begin
                timer_irq <= match;
                if (mode_q == timer_off || tick)
                    presc_cnt <= '0;
                else
                    presc_cnt <= presc_cnt + 1'b1;
                if (match)
                    count_q <= '0;
                else if (tick)
                    count_q <= count_q + 1'b1;
                if (match && mode_q == timer_one_shot)
                    mode_q <= timer_off;
            end
        end
    end

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                timer_ctrl:     rdata = {{(data_width-2){1'b0}}, mode_q};
                timer_prescale: rdata = prescale_q;
                timer_compare:  rdata = compare_q;
                timer_count:    rdata = count_q;
                default:        rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/periph_interrupt_mux.sv ====
// ==========================================================
// Interrupt router: maps source pulses onto the processor
// interrupt lines through per-line pending latches
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module periph_interrupt_mux import periph_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     sel,
    input  wire  [offset_width-1:0] offset,
    input  wire  [data_width-1:0]   data_in,
    input  wire                     write_en,
    output logic [data_width-1:0]   rdata,
    input  wire                     gpio_irq,
    input  wire                     timer_irq,
    output logic [irq_lines-1:0]    interrupt_request
);

    logic                    hit;
    logic                    wr;
    logic [offset_width-1:0] idx;
    irq_source_e             route_q [irq_lines];
    irq_source_e             route_in;
    logic [irq_lines-1:0]    pending_q;
    logic [irq_lines-1:0]    set_vec;
    logic [irq_lines-1:0]    clr_vec;

    assign hit = sel && (offset >= intmux_off) && (offset < intmux_off + intmux_size);
    assign idx = offset - intmux_off;
    assign wr  = hit && write_en;

    // unknown source code reads as src_none
    assign route_in = (data_in[1:0] == 2'd3) ? src_none : irq_source_e'(data_in[1:0]);

    always_comb
    begin
        for (int i = 0; i < irq_lines; i++)
        begin
            set_vec[i] = (route_q[i] == src_gpio && gpio_irq) ||
                         (route_q[i] == src_timer && timer_irq);
        end
    end

    assign clr_vec = (wr && idx == intmux_pending) ? data_in[irq_lines-1:0] : '0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < irq_lines; i++)
                route_q[i] <= src_none;
            pending_q <= '0;
        end
        else
        begin
            if (wr)
            begin
                case (idx)
                    intmux_route0: route_q[0] <= route_in;
                    intmux_route1: route_q[1] <= route_in;
                    intmux_route2: route_q[2] <= route_in;
                    intmux_route3: route_q[3] <= route_in;
                    default: ;
                endcase
            end
            // set wins over write-one-to-clear
            pending_q <= (pending_q & ~clr_vec) | set_vec;
        end
    end

    assign interrupt_request = pending_q;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (idx)
                intmux_route0:  rdata = {{(data_width-2){1'b0}}, route_q[0]};
                intmux_route1:  rdata = {{(data_width-2){1'b0}}, route_q[1]};
                intmux_route2:  rdata = {{(data_width-2){1'b0}}, route_q[2]};
                intmux_route3:  rdata = {{(data_width-2){1'b0}}, route_q[3]};
                intmux_pending: rdata = {{(data_width-irq_lines){1'b0}}, pending_q};
                default:        rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/periph_subsystem.sv ====
// ==========================================================
// Peripheral subsystem: decodes the bus window, forms the
// local offset and merges the read data of all blocks
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module periph_subsystem import periph_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     enable,
    input  wire  [addr_width-1:0]   addr,
    input  wire  [data_width-1:0]   data_in,
    output logic [data_width-1:0]   data_out,
    input  wire                     write_en,
    input  wire  [15:0]             gpi,
    output logic [15:0]             gpo,
    output logic [irq_lines-1:0]    interrupt_request
);

    logic                    window_hit;
    logic [offset_width-1:0] offset;

    logic [data_width-1:0]   rdata_intmux;
    logic [data_width-1:0]   rdata_gpio;
    logic [data_width-1:0]   rdata_timer;

    logic                    gpio_irq;
    logic                    timer_irq;

    // access control
    assign window_hit = enable && (addr >= base_addr) &&
                        (addr < base_addr + addr_width'(total_size));
    assign offset     = offset_width'(addr - base_addr);

    periph_interrupt_mux u_periph_interrupt_mux
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .sel               (window_hit),
        .offset            (offset),
        .data_in           (data_in),
        .write_en          (write_en),
        .rdata             (rdata_intmux),
        .gpio_irq          (gpio_irq),
        .timer_irq         (timer_irq),
        .interrupt_request (interrupt_request)
    );

    periph_gpio u_periph_gpio
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .sel      (window_hit),
        .offset   (offset),
        .data_in  (data_in),
        .write_en (write_en),
        .rdata    (rdata_gpio),
        .gpi      (gpi),
        .gpo      (gpo),
        .gpio_irq (gpio_irq)
    );

    periph_timer u_periph_timer
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .sel       (window_hit),
        .offset    (offset),
        .data_in   (data_in),
        .write_en  (write_en),
        .rdata     (rdata_timer),
        .timer_irq (timer_irq)
    );

    // blocks drive zero when not addressed
    assign data_out = rdata_intmux | rdata_gpio | rdata_timer;

endmodule

`default_nettype wire

// ==== sim/periph_checker.sv ====
// ==========================================================
// Checker: samples the DUT outputs on strobe and compares
// them with the expected values, counting mismatches
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module periph_checker
(
    input  wire          clk,
    input  wire          check_en,
    input  wire  [1:0]   check_kind,
    input  wire  [15:0]  check_exp,
    input  wire  [191:0] check_name,
    input  wire  [7:0]   data_out,
    input  wire  [15:0]  gpo,
    input  wire  [3:0]   interrupt_request,
    output int           check_count,
    output int           error_count
);

    logic [15:0] actual;

    initial
    begin
        check_count = 0;
        error_count = 0;
    end

    // kind 0 read data, 1 gpo, 2 interrupt lines
    always_comb
    begin
        case (check_kind)
            2'd0:    actual = {8'h00, data_out};
            2'd1:    actual = gpo;
            default: actual = {12'h000, interrupt_request};
        endcase
    end

    always @(posedge clk)
    begin
        if (check_en)
        begin
            check_count <= check_count + 1;
            if (actual !== check_exp)
            begin
                error_count <= error_count + 1;
                $display("[ERROR] %0s: expected %h, actual %h", check_name, check_exp, actual);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/periph_subsystem_tb.sv ====
// ==========================================================
// Peripheral subsystem testbench: replays the stimulus file
// on the bus and hands expected values to the checker
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module periph_subsystem_tb;

    logic        clk;
    logic        arst_n;
    logic        enable;
    logic [15:0] addr;
    logic [7:0]  data_in;
    logic        write_en;
    logic [15:0] gpi;
    wire  [7:0]  data_out;
    wire  [15:0] gpo;
    wire  [3:0]  interrupt_request;

    logic           check_en;
    logic [1:0]     check_kind;
    logic [15:0]    check_exp;
    logic [191:0]   check_name;
    int             check_count;
    int             error_count;
    int             bad_ops;
    int             cycles = 0;
    int             cycle_limit = 0;

    // one entry per stimulus line
    logic [31:0]    op_q [$];
    logic [15:0]    addr_q [$];
    logic [15:0]    data_q [$];
    logic [15:0]    exp_q [$];
    logic [191:0]   name_q [$];

    periph_subsystem u_periph_subsystem
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .enable            (enable),
        .addr              (addr),
        .data_in           (data_in),
        .data_out          (data_out),
        .write_en          (write_en),
        .gpi               (gpi),
        .gpo               (gpo),
        .interrupt_request (interrupt_request)
    );

    periph_checker u_periph_checker
    (
        .clk               (clk),
        .check_en          (check_en),
        .check_kind        (check_kind),
        .check_exp         (check_exp),
        .check_name        (check_name),
        .data_out          (data_out),
        .gpo               (gpo),
        .interrupt_request (interrupt_request),
        .check_count       (check_count),
        .error_count       (error_count)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic load_stimulus(output bit ok);
        int           fd;
        string        line;
        logic [31:0]  op;
        logic [15:0]  a;
        logic [15:0]  d;
        logic [15:0]  e;
        logic [191:0] nm;
        ok = 1'b0;
        fd = $fopen("sim/periph_stimulus.txt", "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            cycle_limit = 100;
            while (!$feof(fd))
            begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#")
                begin
                    if ($sscanf(line, "%s %h %h %h %s", op, a, d, e, nm) == 5)
                    begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        exp_q.push_back(e);
                        name_q.push_back(nm);
                        cycle_limit += 4;
                        if (op == "wait")
                            cycle_limit += int'(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one bus cycle per entry, wait entries hold the bus idle
    task automatic run_op(int i);
        @(posedge clk);
        enable     <= 1'b1;
        write_en   <= 1'b0;
        addr       <= addr_q[i];
        data_in    <= data_q[i][7:0];
        check_en   <= 1'b0;
        check_exp  <= exp_q[i];
        check_name <= name_q[i];
        case (op_q[i])
            "wr":
                write_en <= 1'b1;
            "wrd":
            begin
                enable   <= 1'b0;
                write_en <= 1'b1;
            end
            "rd":
            begin
                check_en   <= 1'b1;
                check_kind <= 2'd0;
            end
            "gpo":
            begin
                enable     <= 1'b0;
                check_en   <= 1'b1;
                check_kind <= 2'd1;
            end
            "irq":
            begin
                enable     <= 1'b0;
                check_en   <= 1'b1;
                check_kind <= 2'd2;
            end
            "gpi":
            begin
                enable <= 1'b0;
                gpi    <= data_q[i];
            end
            "wait":
            begin
                enable <= 1'b0;
                repeat (int'(data_q[i]) - 1) @(posedge clk);
            end
            default:
            begin
                enable <= 1'b0;
                bad_ops++;
                $display("unknown operation in stimulus entry %0d", i);
            end
        endcase
    endtask

    initial
    begin
        bit ok;
        clk        = 1'b0;
        arst_n     = 1'b0;
        enable     = 1'b0;
        addr       = '0;
        data_in    = '0;
        write_en   = 1'b0;
        gpi        = '0;
        check_en   = 1'b0;
        check_kind = '0;
        check_exp  = '0;
        check_name = '0;
        bad_ops    = 0;
        load_stimulus(ok);
        if (!ok)
        begin
            $display("could not open the stimulus file");
            $display("RESULT: FAIL");
            $finish;
        end
        else
        begin
            repeat (10) @(posedge clk);
            arst_n <= 1'b1;
            for (int i = 0; i < op_q.size(); i++)
                run_op(i);
            @(posedge clk);
            enable   <= 1'b0;
            write_en <= 1'b0;
            check_en <= 1'b0;
            repeat (2) @(posedge clk);
            @(negedge clk);
            $display("checks %0d, errors %0d, bad operations %0d",
                     check_count, error_count, bad_ops);
            if (error_count == 0 && bad_ops == 0 && check_count > 0)
                $display("RESULT: PASS");
            else
                $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/periph_stimulus.txt ====
# columns: op addr data expected name, all numbers hex
# ops: wr rd wrd(write, enable low) gpi wait(data = cycles) gpo irq
rd   FF00 0000 0000 rst_route0
rd   FF04 0000 0000 rst_pending
rd   FF06 0000 0000 rst_gpo_hi
rd   FF08 0000 0000 rst_gpi_hi
rd   FF09 0000 0000 rst_ctrl
rd   FF0C 0000 0000 rst_count
gpo  0000 0000 0000 rst_gpo
irq  0000 0000 0000 rst_irq
wr   FF0B 0001 0000 route_none_compare
wr   FF09 0002 0000 route_none_periodic
gpi  0000 0001 0000 route_none_gpi_edge
wait 0000 0008 0000 route_none_wait
irq  0000 0000 0000 route_none_irq
wr   FF09 0000 0000 route_none_stop
wr   FF05 00A5 0000 gpo_lo_write
wr   FF06 003C 0000 gpo_hi_write
gpo  0000 0000 3CA5 gpo_value
rd   FF05 0000 00A5 gpo_lo_read
rd   FF06 0000 003C gpo_hi_read
wrd  FF05 00FF 0000 gpo_enable_low
wr   FF0D 0077 0000 outside_above
wr   FE05 0011 0000 outside_below
gpo  0000 0000 3CA5 gpo_unchanged
rd   FF0D 0000 0000 outside_read
wr   FF01 0001 0000 route1_gpio
gpi  0000 1234 0000 gpi_set
wait 0000 0002 0000 gpi_sync_wait
rd   FF07 0000 0034 gpi_lo_read
rd   FF08 0000 0012 gpi_hi_read
gpi  0000 1235 0000 gpi_bit0_rise
wait 0000 0004 0000 gpi_irq_wait
irq  0000 0000 0002 gpio_irq_line1
rd   FF04 0000 0002 gpio_pending
wr   FF04 0002 0000 gpio_pending_clear
irq  0000 0000 0000 gpio_irq_cleared
wr   FF0A 0003 0000 tmr_prescale
wr   FF0B 0004 0000 tmr_compare
wr   FF00 0002 0000 route0_timer
wr   FF09 0002 0000 tmr_periodic
wait 0000 0018 0000 tmr_period_wait
irq  0000 0000 0001 tmr_irq_line0
rd   FF0C 0000 0001 tmr_count_low
rd   FF04 0000 0001 tmr_pending
wr   FF09 0000 0000 tmr_stop
wr   FF04 0001 0000 tmr_pending_clear
rd   FF04 0000 0000 tmr_pending_cleared
wr   FF09 0001 0000 oneshot_start
wait 0000 0018 0000 oneshot_wait
rd   FF09 0000 0000 oneshot_ctrl_off
rd   FF04 0000 0001 oneshot_pending
wr   FF04 0001 0000 oneshot_clear
wait 0000 0018 0000 oneshot_rest_wait
irq  0000 0000 0000 oneshot_stays_clear

// ==== periph_subsystem.f ====
rtl/periph_pkg.sv
rtl/periph_gpio.sv
rtl/periph_timer.sv
rtl/periph_interrupt_mux.sv
rtl/periph_subsystem.sv
sim/periph_checker.sv
sim/periph_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: periph_subsystem

sources:
  - rtl/periph_pkg.sv
  - rtl/periph_gpio.sv
  - rtl/periph_timer.sv
  - rtl/periph_interrupt_mux.sv
  - rtl/periph_subsystem.sv
  - target: simulation
    files:
      - sim/periph_checker.sv
      - sim/periph_subsystem_tb.sv
